// File: build.f
+incdir+include
design/fb_pkg.sv
design/raster_timing.sv
design/sram_ctrl.sv
design/fb_sequencer.sv
design/fb_top.sv
test/sram_model.sv
test/fb_asserts.sv
test/fb_tb.sv

// File: design/fb_pkg.sv
package fb_pkg;

    // framebuffer sequencer states
    typedef enum logic [3:0] {
        idle,
        fetch_issue,
        fetch_wait,
        fetch_shift,
        plot_read,
        plot_read_wait,
        plot_write,
        plot_write_wait,
        erase_write,
        erase_wait
    } fb_state_t;

    // request from the sequencer to the SRAM controller
    typedef enum logic [1:0] {
        op_none,
        op_read,
        op_write
    } sram_op_t;

endpackage

// File: design/fb_sequencer.sv
`timescale 1ns/1ns
`include "fb_config.svh"

module fb_sequencer import fb_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [10:0]              hcount,
    input  logic [9:0]               vcount,
    input  logic                     point_valid,
    input  logic [9:0]               point_x,
    input  logic [8:0]               point_y,
    output logic                     point_credit,
    input  logic                     erase_req,
    output sram_op_t                 op,
    output logic [`FB_ADDR_BITS-1:0] addr,
    output logic [`FB_WORD_BITS-1:0] wdata,
    input  logic                     ready,
    input  logic [`FB_WORD_BITS-1:0] rdata,
    output logic                     pixel
);

    localparam int AW        = `FB_ADDR_BITS;
    localparam int WB        = `FB_WORD_BITS;
    localparam int WB_LOG    = $clog2(WB);
    localparam int LINE_BITS = `FB_H_VISIBLE;
    localparam int PIX_W     = $clog2(LINE_BITS);
    localparam int IDX_W     = $clog2(`FB_WORDS_PER_LINE);
    localparam int QD        = `FB_POINT_DEPTH;
    localparam int QP_W      = $clog2(QD);
    localparam int QC_W      = QP_W + 1;

    localparam logic [10:0]    H_VIS      = 11'(`FB_H_VISIBLE);
    localparam logic [9:0]     V_VIS      = 10'(`FB_V_VISIBLE);
    localparam logic [9:0]     V_LAST     = 10'(`FB_V_TOTAL - 1);
    localparam logic [AW-1:0]  WPL        = AW'(`FB_WORDS_PER_LINE);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(`FB_WORDS_PER_LINE - 1);
    localparam logic [AW-1:0]  ERASE_LAST = AW'(`FB_V_VISIBLE * `FB_WORDS_PER_LINE - 1);
    localparam logic [QP_W-1:0] PTR_LAST  = QP_W'(QD - 1);
    localparam logic [WB-1:0]  LEFT_BIT   = {1'b1, {(WB - 1){1'b0}}};

    fb_state_t state;

    // circular point queue
    logic [9:0]      q_x [QD];
    logic [8:0]      q_y [QD];
    logic [QP_W-1:0] wr_ptr;
    logic [QP_W-1:0] rd_ptr;
    logic [QC_W-1:0] q_count;
    logic            pop;

    logic                 erase_pend;
    logic [IDX_W-1:0]     word_idx;
    logic [9:0]           fetch_y;     // line the fetch is for
    logic                 fetch_line;  // next line is visible
    logic [WB-1:0]        plot_mask;
    logic [LINE_BITS-1:0] line_buf;    // word 0 ends up in the top bits
    logic [PIX_W-1:0]     pix_sel;

    assign pop          = (state == plot_read);
    assign point_credit = pop;  // one credit back per dequeue

    assign fetch_y    = (vcount == V_LAST) ? '0 : vcount + 10'd1;
    assign fetch_line = (vcount < V_VIS - 10'd1) || (vcount == V_LAST);

    always_ff @(posedge clk) begin
        if (point_valid) begin
            q_x[wr_ptr] <= point_x;
            q_y[wr_ptr] <= point_y;
        end
    end

    // credits keep the source from ever overrunning the queue
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end else begin
            if (point_valid) begin
                wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
            end
            q_count <= q_count + QC_W'(point_valid) - QC_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= idle;
            op         <= op_none;
            word_idx   <= '0;
            erase_pend <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (hcount == H_VIS && fetch_line) begin
                        word_idx <= '0;
                        state    <= fetch_issue;
                    end else if (hcount == '0 && vcount == V_VIS + 10'd1 && erase_pend) begin
                        erase_pend <= 1'b0;
                        addr       <= '0;
                        state      <= erase_write;
                    end else if (vcount == V_VIS && q_count != '0) begin
                        state <= plot_read;  // queue drains on the first blank line
                    end
                end
                fetch_issue: begin
                    op    <= op_read;
                    addr  <= AW'(fetch_y) * WPL;
                    state <= fetch_wait;
                end
                fetch_wait: begin
                    if (ready) begin
                        op       <= op_none;
                        line_buf <= {line_buf[LINE_BITS-WB-1:0], rdata};
                        state    <= fetch_shift;
                    end
                end
                fetch_shift: begin
                    if (word_idx == IDX_LAST) begin
                        state <= idle;
                    end else begin
                        word_idx <= word_idx + 1'b1;
                        op       <= op_read;
                        addr     <= addr + 1'b1;
                        state    <= fetch_wait;
                    end
                end
                plot_read: begin
                    op        <= op_read;
                    addr      <= AW'(q_y[rd_ptr]) * WPL + AW'(q_x[rd_ptr] >> WB_LOG);
                    plot_mask <= LEFT_BIT >> q_x[rd_ptr][WB_LOG-1:0];  // bit 15 is leftmost
                    state     <= plot_read_wait;
                end
                plot_read_wait: begin
                    if (ready) begin
                        op    <= op_none;
                        wdata <= rdata | plot_mask;  // keep the other pixels of the word
                        state <= plot_write;
                    end
                end
                plot_write: begin
                    op    <= op_write;
                    state <= plot_write_wait;
                end
                plot_write_wait: begin
                    if (ready) begin
                        op    <= op_none;
                        state <= idle;
                    end
                end
                erase_write: begin
                    op    <= op_write;
                    wdata <= '0;
                    state <= erase_wait;
                end
                erase_wait: begin
                    if (ready) begin
                        op <= op_none;
                        if (addr == ERASE_LAST) begin
                            state <= idle;
                        end else begin
                            addr  <= addr + 1'b1;
                            state <= erase_write;
                        end
                    end
                end
                default: state <= idle;
            endcase
            if (erase_req) begin
                erase_pend <= 1'b1;  // served at the next erase window
            end
        end
    end

    // leftmost pixel sits in the msb of the buffer
    assign pix_sel = PIX_W'(LINE_BITS - 1) - hcount[PIX_W-1:0];
    assign pixel   = line_buf[pix_sel];

endmodule

// File: design/fb_top.sv
`timescale 1ns/1ns
`include "fb_config.svh"

module fb_top import fb_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     point_valid,
    input  logic [9:0]               point_x,
    input  logic [8:0]               point_y,
    output logic                     point_credit,
    input  logic                     erase_req,
    output logic                     hsync,
    output logic                     vsync,
    output logic                     blank,
    output logic                     pixel,
    output logic [`FB_ADDR_BITS-1:0] sram_addr,
    input  logic [`FB_WORD_BITS-1:0] sram_din,
    output logic [`FB_WORD_BITS-1:0] sram_dout,
    output logic                     sram_dout_en,
    output logic                     sram_oe_n,
    output logic                     sram_we_n,
    output logic                     sram_cs_n
);

    logic [10:0]              hcount;
    logic [9:0]               vcount;
    sram_op_t                 op;
    logic [`FB_ADDR_BITS-1:0] addr;
    logic [`FB_WORD_BITS-1:0] wdata;
    logic [`FB_WORD_BITS-1:0] rdata;
    logic                     ready;

    raster_timing timing_i (
        .clk    (clk),
        .rst    (rst),
        .hcount (hcount),
        .vcount (vcount),
        .hsync  (hsync),
        .vsync  (vsync),
        .blank  (blank)
    );

    fb_sequencer seq_i (
        .clk          (clk),
        .rst          (rst),
        .hcount       (hcount),
        .vcount       (vcount),
        .point_valid  (point_valid),
        .point_x      (point_x),
        .point_y      (point_y),
        .point_credit (point_credit),
        .erase_req    (erase_req),
        .op           (op),
        .addr         (addr),
        .wdata        (wdata),
        .ready        (ready),
        .rdata        (rdata),
        .pixel        (pixel)
    );

    sram_ctrl sram_i (
        .clk          (clk),
        .rst          (rst),
        .op           (op),
        .addr         (addr),
        .wdata        (wdata),
        .ready        (ready),
        .rdata        (rdata),
        .sram_addr    (sram_addr),
        .sram_din     (sram_din),
        .sram_dout    (sram_dout),
        .sram_dout_en (sram_dout_en),
        .sram_oe_n    (sram_oe_n),
        .sram_we_n    (sram_we_n),
        .sram_cs_n    (sram_cs_n)
    );

endmodule

// File: design/raster_timing.sv
`timescale 1ns/1ns
`include "fb_config.svh"

module raster_timing (
    input  logic        clk,
    input  logic        rst,
    output logic [10:0] hcount,
    output logic [9:0]  vcount,
    output logic        hsync,
    output logic        vsync,
    output logic        blank
);

    localparam logic [10:0] H_VIS    = 11'(`FB_H_VISIBLE);
    localparam logic [10:0] H_TOTAL  = 11'(`FB_H_TOTAL);
    localparam logic [10:0] HS_START = 11'(`FB_HSYNC_START);
    localparam logic [10:0] HS_END   = 11'(`FB_HSYNC_END);
    localparam logic [9:0]  V_VIS    = 10'(`FB_V_VISIBLE);
    localparam logic [9:0]  V_TOTAL  = 10'(`FB_V_TOTAL);
    localparam logic [9:0]  VS_LINE  = 10'(`FB_VSYNC_LINE);

    logic [10:0] h_next;
    logic [9:0]  v_next;
    logic        line_end;

    assign line_end = (hcount == H_TOTAL - 11'd1);
    assign h_next   = line_end ? '0 : hcount + 11'd1;

    always_comb begin
        v_next = vcount;
        if (line_end) begin
            v_next = (vcount == V_TOTAL - 10'd1) ? '0 : vcount + 10'd1;
        end
    end

    // decode from the next count so sync and blank line up with the counters
    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            blank  <= 1'b0;  // 0,0 is a visible pixel
        end else begin
            hcount <= h_next;
            vcount <= v_next;
            hsync  <= (h_next >= HS_START) && (h_next < HS_END);
            vsync  <= (v_next == VS_LINE);  // whole line
            blank  <= (h_next >= H_VIS) || (v_next >= V_VIS);
        end
    end

endmodule

// File: design/sram_ctrl.sv
`timescale 1ns/1ns
`include "fb_config.svh"

module sram_ctrl import fb_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  sram_op_t                 op,
    input  logic [`FB_ADDR_BITS-1:0] addr,
    input  logic [`FB_WORD_BITS-1:0] wdata,
    output logic                     ready,
    output logic [`FB_WORD_BITS-1:0] rdata,
    output logic [`FB_ADDR_BITS-1:0] sram_addr,
    input  logic [`FB_WORD_BITS-1:0] sram_din,
    output logic [`FB_WORD_BITS-1:0] sram_dout,
    output logic                     sram_dout_en,
    output logic                     sram_oe_n,
    output logic                     sram_we_n,
    output logic                     sram_cs_n
);

    localparam int CNT_W = $clog2(`FB_SRAM_WAIT + 1);

    sram_op_t         cur_op;    // operation on the pins, op_none when idle
    logic [CNT_W-1:0] wait_cnt;  // strobe cycles left
    logic             accept;
    logic             last_cycle;

    // the requester holds op through the ready cycle, so skip that one
    assign accept     = (cur_op == op_none) && !ready && (op != op_none);
    assign last_cycle = (cur_op != op_none) && (wait_cnt == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            cur_op   <= op_none;
            wait_cnt <= '0;
            ready    <= 1'b0;
        end else begin
            ready <= 1'b0;
            if (accept) begin
                cur_op   <= op;
                wait_cnt <= CNT_W'(`FB_SRAM_WAIT - 1);
            end else if (last_cycle) begin
                cur_op <= op_none;
                ready  <= 1'b1;
            end else if (cur_op != op_none) begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end
    end

    // address and write data latched with the request
    always_ff @(posedge clk) begin
        if (accept) begin
            sram_addr <= addr;
            sram_dout <= wdata;
        end
    end

    // sample the bus at the end of the read strobe
    always_ff @(posedge clk) begin
        if (last_cycle && cur_op == op_read) begin
            rdata <= sram_din;
        end
    end

    // strobes come straight off the operation register
    assign sram_cs_n    = (cur_op == op_none);
    assign sram_oe_n    = (cur_op != op_read);
    assign sram_we_n    = (cur_op != op_write);
    assign sram_dout_en = (cur_op == op_write);

endmodule

// File: include/fb_config.svh
`ifndef FB_CONFIG_SVH
`define FB_CONFIG_SVH

// screen geometry, small enough for a quick simulation
`define FB_H_VISIBLE      64
`define FB_H_TOTAL        96
`define FB_V_VISIBLE      8
`define FB_V_TOTAL        12

// sync positions in pixels and lines
`define FB_HSYNC_START    72
`define FB_HSYNC_END      80
`define FB_VSYNC_LINE     9

// external SRAM
`define FB_WORD_BITS      16
`define FB_WORDS_PER_LINE 4   // FB_H_VISIBLE / FB_WORD_BITS
`define FB_ADDR_BITS      18
`define FB_SRAM_WAIT      2   // clk cycles per strobe

// point queue depth, equal to the credits held by the source after reset
`define FB_POINT_DEPTH    4

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the framebuffer testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f build.f \
    --top-module fb_tb \
    -o fb_sim

./obj_dir/fb_sim | tee sim.log

grep -q "TB PASSED" sim.log

// File: test/fb_asserts.sv
`timescale 1ns/1ns
`include "fb_config.svh"

module fb_asserts (
    input logic clk,
    input logic rst,
    input logic point_valid,
    input logic point_credit,
    input logic vsync,
    input logic sram_dout_en,
    input logic sram_oe_n,
    input logic sram_we_n
);

    int credits;    // credits the source still holds
    int vs_len;     // clk cycles of the current vsync pulse
    int fails = 0;  // failed assertions so far

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= `FB_POINT_DEPTH;
            vs_len  <= 0;
        end else begin
            credits <= credits - (point_valid ? 1 : 0) + (point_credit ? 1 : 0);
            vs_len  <= vsync ? vs_len + 1 : 0;
        end
    end

    credit_range: assert property (@(posedge clk) disable iff (rst)
        credits >= 0 && credits <= `FB_POINT_DEPTH)
        else begin
            fails++;
            $error("credit count out of range");
        end

    oe_we_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(!sram_oe_n && !sram_we_n))
        else begin
            fails++;
            $error("output enable and write enable low together");
        end

    drive_only_on_write: assert property (@(posedge clk) disable iff (rst)
        sram_dout_en |-> !sram_we_n)
        else begin
            fails++;
            $error("data bus driven outside a write");
        end

    // vsync spans one full line
    vsync_one_line: assert property (@(posedge clk) disable iff (rst)
        $fell(vsync) |-> vs_len == `FB_H_TOTAL)
        else begin
            fails++;
            $error("vsync length is not one line");
        end

endmodule

// File: test/fb_tb.sv
`timescale 1ns/1ns
`include "fb_config.svh"

module fb_tb;

    localparam int H_VIS    = `FB_H_VISIBLE;
    localparam int V_VIS    = `FB_V_VISIBLE;
    localparam int DEPTH    = `FB_POINT_DEPTH;
    localparam int H_TOTAL  = `FB_H_TOTAL;
    localparam int HS_START = `FB_HSYNC_START;
    localparam int HS_END   = `FB_HSYNC_END;

    logic        clk;
    logic        rst;
    logic        point_valid;
    logic [9:0]  point_x;
    logic [8:0]  point_y;
    logic        point_credit;
    logic        erase_req;
    logic        hsync;
    logic        vsync;
    logic        blank;
    logic        pixel;
    logic [`FB_ADDR_BITS-1:0] sram_addr;
    logic [`FB_WORD_BITS-1:0] sram_din;
    logic [`FB_WORD_BITS-1:0] sram_dout;
    logic        sram_dout_en;
    logic        sram_oe_n;
    logic        sram_we_n;
    logic        sram_cs_n;

    // test table read from the data file
    int t_np[$];
    int t_er[$];
    int t_nl[$];
    int pt_x[$];
    int pt_y[$];
    int lt_x[$];
    int lt_y[$];

    integer seed = 32'h150c;
    int sent;
    int returned;
    int cycles;
    int limit;
    int errors;
    int tests_failed;
    int tests_run;

    // frame capture state
    logic cap [V_VIS][H_VIS];
    int   cx;
    int   cy;
    logic armed;
    int   frames_started;
    int   frames_done;

    // horizontal position for the hsync check
    int   hpos;
    logic hpos_ok;
    logic blank_q;

    fb_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .point_valid  (point_valid),
        .point_x      (point_x),
        .point_y      (point_y),
        .point_credit (point_credit),
        .erase_req    (erase_req),
        .hsync        (hsync),
        .vsync        (vsync),
        .blank        (blank),
        .pixel        (pixel),
        .sram_addr    (sram_addr),
        .sram_din     (sram_din),
        .sram_dout    (sram_dout),
        .sram_dout_en (sram_dout_en),
        .sram_oe_n    (sram_oe_n),
        .sram_we_n    (sram_we_n),
        .sram_cs_n    (sram_cs_n)
    );

    sram_model sram_i (
        .addr    (sram_addr),
        .din     (sram_dout),
        .dout    (sram_din),
        .dout_en (sram_dout_en),
        .oe_n    (sram_oe_n),
        .we_n    (sram_we_n),
        .cs_n    (sram_cs_n)
    );

    bind fb_top fb_asserts asserts_i (.*);

    always #20 clk = ~clk;

    function automatic int credits_left();
        return DEPTH - sent + returned;
    endfunction

    always @(negedge clk) begin
        if (point_credit === 1'b1) returned++;
    end

    // x and y follow blank, vsync restarts the frame
    always @(negedge clk) begin
        if (vsync === 1'b1) begin
            cx    = 0;
            cy    = 0;
            armed = 1'b1;
        end else if (armed && blank === 1'b0) begin
            if (cx == 0 && cy == 0) frames_started++;
            cap[cy][cx] = (pixel === 1'b1);
            cx++;
            if (cx == H_VIS) begin
                cx = 0;
                cy++;
                if (cy == V_VIS) begin
                    frames_done++;
                    armed = 1'b0;
                end
            end
        end
    end

    // a line restarts where blank falls, hsync sits at a fixed pixel window
    always @(negedge clk) begin
        if (rst === 1'b1) begin
            hpos_ok = 1'b0;
        end else if (blank_q === 1'b1 && blank === 1'b0) begin
            hpos    = 0;
            hpos_ok = 1'b1;
        end else if (hpos_ok) begin
            hpos = (hpos + 1) % H_TOTAL;
        end
        blank_q = blank;
        if (hpos_ok) begin
            assert (hsync === (hpos >= HS_START && hpos < HS_END))
            else begin
                $display("[FAIL] %0t ns: hsync is %b at pixel %0d of the line",
                         $time, hsync, hpos);
                errors++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout: no result after %0d clock cycles", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic read_tests();
        int fd;
        int n;
        int a;
        int b;
        int c;
        byte tag;
        string line;
        fd = $fopen("test/fb_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/fb_testdata.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%c %d %d %d", tag, a, b, c);
                    if (tag == "T") begin
                        t_np.push_back(a);
                        t_er.push_back(b);
                        t_nl.push_back(c);
                    end else if (tag == "P") begin
                        pt_x.push_back(a);
                        pt_y.push_back(b);
                    end else if (tag == "L") begin
                        lt_x.push_back(a);
                        lt_y.push_back(b);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic send_point(input int x, input int y);
        while (credits_left() == 0) @(negedge clk);
        point_valid = 1'b1;
        point_x     = 10'(x);
        point_y     = 9'(y);
        sent++;
        @(negedge clk);
        point_valid = 1'b0;
    endtask

    // test i is driven in frame i+1
    task automatic drive_tests();
        int pi;
        int gap;
        pi = 0;
        for (int i = 0; i < t_np.size(); i++) begin
            wait (frames_started >= i + 2);
            assert (credits_left() == DEPTH)
            else begin
                $display("[FAIL] %0t ns: test %0d starts with %0d credits, expected %0d",
                         $time, i, credits_left(), DEPTH);
                errors++;
            end
            for (int k = 0; k < t_np[i]; k++) begin
                gap = (t_np[i] >= DEPTH) ? 0 : ($random(seed) & 3);  // full burst back to back
                repeat (gap) @(negedge clk);
                send_point(pt_x[pi], pt_y[pi]);
                pi++;
            end
            if (t_er[i] != 0) begin
                erase_req = 1'b1;
                @(negedge clk);
                erase_req = 1'b0;
            end
        end
    endtask

    task automatic check_frame(input string name, input int first, input int n);
        logic want [V_VIS][H_VIS];
        int bad;
        bad = 0;
        for (int y = 0; y < V_VIS; y++) begin
            for (int x = 0; x < H_VIS; x++) want[y][x] = 1'b0;
        end
        for (int k = first; k < first + n; k++) want[lt_y[k]][lt_x[k]] = 1'b1;
        for (int y = 0; y < V_VIS; y++) begin
            for (int x = 0; x < H_VIS; x++) begin
                assert (cap[y][x] == want[y][x])
                else begin
                    $display("[FAIL] %0t ns: %s pixel (%0d,%0d) expected %0d got %0d",
                             $time, name, x, y, want[y][x], cap[y][x]);
                    bad++;
                end
            end
        end
        tests_run++;
        errors += bad;
        if (bad != 0) tests_failed++;
        $display("%s: %s, %0d pixel errors", name, (bad == 0) ? "ok" : "mismatch", bad);
    endtask

    // test i is seen in frame i+2
    task automatic check_tests();
        int li;
        li = 0;
        wait (frames_done >= 1);
        check_frame("reset frame", 0, 0);
        for (int i = 0; i < t_np.size(); i++) begin
            wait (frames_done >= i + 3);
            check_frame($sformatf("test %0d", i), li, t_nl[i]);
            li += t_nl[i];
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        point_valid  = 1'b0;
        point_x      = '0;
        point_y      = '0;
        erase_req    = 1'b0;
        sent         = 0;
        returned     = 0;
        cycles       = 0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        armed        = 1'b0;
        cx           = 0;
        cy           = 0;
        frames_started = 0;
        frames_done    = 0;
        hpos         = 0;
        hpos_ok      = 1'b0;
        blank_q      = 1'b0;
        read_tests();
        // one frame before the reset frame, the reset frame, then one per test
        limit = (t_np.size() + 3) * `FB_H_TOTAL * `FB_V_TOTAL;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        fork
            drive_tests();
            check_tests();
        join
        errors += dut_i.asserts_i.fails;  // bound checker failures
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: test/fb_testdata.txt
# T npoints erase nlit : one test, followed by its P and L lines
# P x y : point to send ; L x y : pixel lit in the following frame
T 0 0 0
T 1 0 1
P 5 2
L 5 2
T 1 0 2
P 6 2
L 5 2
L 6 2
T 1 0 3
P 40 6
L 5 2
L 6 2
L 40 6
T 4 0 7
P 0 0
P 63 7
P 17 3
P 31 4
L 5 2
L 6 2
L 40 6
L 0 0
L 63 7
L 17 3
L 31 4
T 2 1 0
P 10 1
P 11 1
T 1 0 1
P 1 1
L 1 1

// File: test/sram_model.sv
`timescale 1ns/1ns
`include "fb_config.svh"

module sram_model (
    input  logic [`FB_ADDR_BITS-1:0] addr,
    input  logic [`FB_WORD_BITS-1:0] din,
    output logic [`FB_WORD_BITS-1:0] dout,
    input  logic                     dout_en,
    input  logic                     oe_n,
    input  logic                     we_n,
    input  logic                     cs_n
);

    localparam int DEPTH = 1 << `FB_ADDR_BITS;

    logic [`FB_WORD_BITS-1:0] mem [DEPTH];
    logic [`FB_WORD_BITS-1:0] bus_data;  // last word the controller drove

    // a cleared array, so the first frame reads back dark
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // the bus carries write data only while the controller drives it
    always_latch begin
        if (dout_en) begin
            bus_data = din;
        end
    end

    // data is taken at the rising edge of the write strobe
    always @(posedge we_n) begin
        mem[addr] <= bus_data;
    end

    // read data only while selected with output enable low
    assign dout = (!cs_n && !oe_n) ? mem[addr] : '0;

endmodule
